//--- noc_pkg.sv
//====================
// Shared router definitions
// Port indices and flit kinds
// Routing header, payload union, flit word
//====================
`default_nettype none

package noc_pkg;

  // Fixed by the 2D mesh topology
  localparam int unsigned NumPorts = 5;

  // Router port indices
  typedef enum logic [2:0] {
    Local = 3'd0,
    North = 3'd1,
    East  = 3'd2,
    South = 3'd3,
    West  = 3'd4
  } port_e;

  // One mesh coordinate
  localparam int unsigned CoordWidth = 4;

  typedef logic [CoordWidth-1:0] coord_t;

  // Position of a flit inside its packet
  typedef enum logic [1:0] {
    Head   = 2'd0,
    Body   = 2'd1,
    Tail   = 2'd2,
    Single = 2'd3
  } flit_kind_e;

  // Header view, carried by head and single flits
  typedef struct packed {
    coord_t      dst_x;
    coord_t      dst_y;
    logic [7:0]  src_tag;
    logic [15:0] seq_num;
  } route_hdr_t;

  // Body and tail flits read the same bits as plain data
  typedef union packed {
    route_hdr_t  hdr;
    logic [31:0] data;
  } flit_payload_u;

  typedef struct packed {
    flit_kind_e    kind;
    flit_payload_u payload;
  } flit_t;

endpackage

`default_nettype wire

//--- noc_in_fifo.sv
//====================
// Input flit FIFO
// Circular buffer, valid/ready on both sides
//====================
`timescale 1ns/100ps
`default_nettype none

module noc_in_fifo #(
  parameter int unsigned InFifoDepth = 4
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  logic           valid_i,
  output logic           ready_o,
  input  noc_pkg::flit_t data_i,
  output logic           valid_o,
  input  logic           ready_i,
  output noc_pkg::flit_t data_o
);
  import noc_pkg::*;

  localparam int unsigned PtrWidth = (InFifoDepth > 1) ? $clog2(InFifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(InFifoDepth + 1);

  flit_t               mem_q [InFifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full, push, pop;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    return (ptr == PtrWidth'(InFifoDepth - 1)) ? '0 : ptr + PtrWidth'(1);
  endfunction

  assign full    = (count_q == CntWidth'(InFifoDepth));
  // A full buffer still takes a flit when the head leaves in the same cycle
  assign ready_o = !full || ready_i;
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)  rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CntWidth'(1);
        2'b01:   count_q <= count_q - CntWidth'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_q <= CntWidth'(InFifoDepth))
    else $error("FIFO count above depth");

  // A write into a full buffer lands on the slot that is read out
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push && full |-> pop && wr_ptr_q == rd_ptr_q)
    else $error("FIFO overwrote a waiting flit");

endmodule

`default_nettype wire

//--- noc_xy_route.sv
//====================
// XY route selector
// Decodes the head flit against the local coordinate
// Holds the route until the tail has passed
//====================
`timescale 1ns/100ps
`default_nettype none

module noc_xy_route #(
  parameter int unsigned PortIdx = 0
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  noc_pkg::coord_t              xy_x_i,
  input  noc_pkg::coord_t              xy_y_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  input  noc_pkg::flit_t               data_i,
  output logic                         valid_o,
  input  logic                         ready_i,
  output noc_pkg::flit_t               data_o,
  output logic [noc_pkg::NumPorts-1:0] route_o
);
  import noc_pkg::*;

  route_hdr_t          hdr;
  logic                is_head;
  logic                xfer;
  logic [NumPorts-1:0] xy_mask;
  logic [NumPorts-1:0] route_q;

  assign hdr     = data_i.payload.hdr;
  assign is_head = (data_i.kind == Head) || (data_i.kind == Single);
  assign xfer    = valid_i && ready_i;

  // Dimension order with X first and then Y
  always_comb begin
    xy_mask = '0;
    if (hdr.dst_x > xy_x_i)      xy_mask[East]  = 1'b1;
    else if (hdr.dst_x < xy_x_i) xy_mask[West]  = 1'b1;
    else if (hdr.dst_y > xy_y_i) xy_mask[North] = 1'b1;
    else if (hdr.dst_y < xy_y_i) xy_mask[South] = 1'b1;
    else                         xy_mask[Local] = 1'b1;
  end

  // Body and tail words carry no header, so they follow the stored route
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      route_q <= '0;
    end else if (xfer && data_i.kind == Head) begin
      route_q <= xy_mask;
    end else if (xfer && data_i.kind == Tail) begin
      route_q <= '0;
    end
  end

  assign route_o = is_head ? xy_mask : route_q;
  assign valid_o = valid_i;
  assign ready_o = ready_i;
  assign data_o  = data_i;

  a_route_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> $onehot(route_o))
    else $error("Route mask not one-hot on port %0d", PortIdx);

  // Y inputs may only continue in Y or eject
  if (PortIdx == North || PortIdx == South) begin : gen_no_yx_turn
    a_no_yx_turn: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_o |-> !route_o[East] && !route_o[West])
      else $error("Y to X turn on port %0d", PortIdx);
  end

endmodule

`default_nettype wire

//--- noc_wormhole_arb.sv
//====================
// Wormhole output arbiter
// Round-robin pick, locked from head to tail
//====================
`timescale 1ns/100ps
`default_nettype none

module noc_wormhole_arb (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic           [noc_pkg::NumPorts-1:0] valid_i,
  output logic           [noc_pkg::NumPorts-1:0] ready_o,
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0] data_i,
  output logic                                   valid_o,
  input  logic                                   ready_i,
  output noc_pkg::flit_t                         data_o
);
  import noc_pkg::*;

  localparam int unsigned IdxWidth = $clog2(NumPorts);

  logic                lock_q, lock_d;
  logic                hold_q, hold_d;
  logic [IdxWidth-1:0] grant_q, grant_d;
  logic [IdxWidth-1:0] last_q, last_d;
  logic [IdxWidth-1:0] rr_idx, sel_idx;
  logic                rr_found, fixed;

  // Search starts one past the last winner
  always_comb begin
    int cand;
    rr_found = 1'b0;
    rr_idx   = last_q;
    for (int k = 1; k <= NumPorts; k++) begin
      cand = (int'(last_q) + k) % NumPorts;
      if (!rr_found && valid_i[cand]) begin
        rr_found = 1'b1;
        rr_idx   = IdxWidth'(cand);
      end
    end
  end

  // Grant is fixed inside a packet and while a stalled flit waits
  assign fixed   = lock_q || hold_q;
  assign sel_idx = fixed ? grant_q : rr_idx;
  assign valid_o = fixed ? valid_i[grant_q] : rr_found;
  assign data_o  = data_i[sel_idx];

  always_comb begin
    ready_o          = '0;
    ready_o[sel_idx] = valid_o && ready_i;
  end

  always_comb begin
    lock_d  = lock_q;
    hold_d  = 1'b0;
    grant_d = grant_q;
    last_d  = last_q;
    if (valid_o && ready_i) begin
      last_d = sel_idx;
      if (data_o.kind == Head) begin
        lock_d  = 1'b1;
        grant_d = sel_idx;
      end else if (data_o.kind == Tail) begin
        lock_d = 1'b0;
      end
    end else if (valid_o) begin
      // A stalled output keeps the same input on the port
      hold_d  = 1'b1;
      grant_d = sel_idx;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q  <= 1'b0;
      hold_q  <= 1'b0;
      grant_q <= '0;
      last_q  <= IdxWidth'(NumPorts - 1);
    end else begin
      lock_q  <= lock_d;
      hold_q  <= hold_d;
      grant_q <= grant_d;
      last_q  <= last_d;
    end
  end

  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o))
    else $error("Output changed during back-pressure");

endmodule

`default_nettype wire

//--- noc_router.sv
//====================
// Five-port wormhole router tile
// Input FIFO and XY selector per port
// One wormhole arbiter per output
//====================
`timescale 1ns/100ps
`default_nettype none

module noc_router #(
  parameter int unsigned InFifoDepth = 4
) (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  noc_pkg::coord_t                        xy_x_i,
  input  noc_pkg::coord_t                        xy_y_i,
  input  logic           [noc_pkg::NumPorts-1:0] in_valid_i,
  output logic           [noc_pkg::NumPorts-1:0] in_ready_o,
  input  noc_pkg::flit_t [noc_pkg::NumPorts-1:0] in_data_i,
  output logic           [noc_pkg::NumPorts-1:0] out_valid_o,
  input  logic           [noc_pkg::NumPorts-1:0] out_ready_i,
  output noc_pkg::flit_t [noc_pkg::NumPorts-1:0] out_data_o
);
  import noc_pkg::*;

  // Buffered side of each input
  flit_t [NumPorts-1:0] fifo_data;
  logic  [NumPorts-1:0] fifo_valid;
  logic  [NumPorts-1:0] fifo_ready;

  // Route selector outputs indexed by input
  flit_t [NumPorts-1:0]                route_data;
  logic  [NumPorts-1:0]                route_valid;
  logic  [NumPorts-1:0]                route_ready;
  logic  [NumPorts-1:0][NumPorts-1:0] route_mask;

  // Requests and grants seen by each arbiter as [out][in]
  logic [NumPorts-1:0][NumPorts-1:0] masked_valid;
  logic [NumPorts-1:0][NumPorts-1:0] masked_ready;
  // Grants turned around to [in][out]
  logic [NumPorts-1:0][NumPorts-1:0] grant_ready;

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    noc_in_fifo #(
      .InFifoDepth ( InFifoDepth )
    ) i_in_fifo (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .valid_i ( in_valid_i[i] ),
      .ready_o ( in_ready_o[i] ),
      .data_i  ( in_data_i[i]  ),
      .valid_o ( fifo_valid[i] ),
      .ready_i ( fifo_ready[i] ),
      .data_o  ( fifo_data[i]  )
    );

    noc_xy_route #(
      .PortIdx ( i )
    ) i_xy_route (
      .clk_i   ( clk_i          ),
      .rst_n_i ( rst_n_i        ),
      .xy_x_i  ( xy_x_i         ),
      .xy_y_i  ( xy_y_i         ),
      .valid_i ( fifo_valid[i]  ),
      .ready_o ( fifo_ready[i]  ),
      .data_i  ( fifo_data[i]   ),
      .valid_o ( route_valid[i] ),
      .ready_i ( route_ready[i] ),
      .data_o  ( route_data[i]  ),
      .route_o ( route_mask[i]  )
    );

    // Only the output picked by the mask may release the input
    assign route_ready[i] = |(grant_ready[i] & route_mask[i]);
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_mask_out
    for (genvar i = 0; i < NumPorts; i++) begin : gen_mask_in
      assign masked_valid[o][i] = route_valid[i] && route_mask[i][o];
      assign grant_ready[i][o]  = masked_ready[o][i];
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    noc_wormhole_arb i_wormhole_arb (
      .clk_i   ( clk_i           ),
      .rst_n_i ( rst_n_i         ),
      .valid_i ( masked_valid[o] ),
      .ready_o ( masked_ready[o] ),
      .data_i  ( route_data      ),
      .valid_o ( out_valid_o[o]  ),
      .ready_i ( out_ready_i[o]  ),
      .data_o  ( out_data_o[o]   )
    );
  end

  // Upstream senders must keep a refused flit on the link
  for (genvar i = 0; i < NumPorts; i++) begin : gen_in_assert
    a_in_valid_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      in_valid_i[i] && !in_ready_o[i] |=> in_valid_i[i])
      else $error("Input %0d dropped valid before ready", i);
  end

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
//====================
// Testbench clock and reset
// 4 ns clock, reset held for 16 cycles
//====================
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter real ClkPeriod   = 4.0,
  parameter int  ResetCycles = 16
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2.0) clk_o = ~clk_o;
  end

  // Reset falls before the first clock edge and rises on a falling edge
  initial begin
    rst_n_o = 1'b1;
    #(ClkPeriod / 4.0);
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb_noc_router.sv
//====================
// Router testbench
// Random packets on all five inputs, random output stalls
// Checking assertions for reset, routing, wormhole, order, back-pressure
//====================
`timescale 1ns/100ps
`default_nettype none

module tb_noc_router;
  import noc_pkg::*;

  localparam int     InFifoDepth  = 4;
  localparam int     NumPkts      = 40;
  localparam int     StimTimeout  = 20000;
  localparam int     DrainTimeout = 2000;
  localparam int     BurstTimeout = 50;
  localparam coord_t LocalX       = 4'd2;
  localparam coord_t LocalY       = 4'd2;

  logic                 clk, rst_n, rst_seen_q;
  logic [NumPorts-1:0]  in_valid, in_ready, out_valid, out_ready, accepted, active;
  flit_t [NumPorts-1:0] in_data, out_data;
  flit_t                prev_data_q [NumPorts];
  logic [NumPorts-1:0]  open_q;
  logic [7:0]           tag_q [NumPorts];
  logic [15:0]          seq_q [NumPorts];
  logic [15:0]          exp_seq_q [256];
  integer               seed = 80137;
  int                   error_count = 0, sent_count = 0, rcv_count;
  int                   pkt_len [NumPorts], flit_idx [NumPorts], pkts_sent [NumPorts];
  logic [15:0]          seq_num [NumPorts];
  coord_t               dst_x [NumPorts], dst_y [NumPorts];
  int                   cycles, burst_count;
  logic                 full_seen;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  noc_router #(.InFifoDepth(InFifoDepth)) DUT (
    .clk_i(clk), .rst_n_i(rst_n), .xy_x_i(LocalX), .xy_y_i(LocalY),
    .in_valid_i(in_valid), .in_ready_o(in_ready), .in_data_i(in_data),
    .out_valid_o(out_valid), .out_ready_i(out_ready), .out_data_o(out_data)
  );

  // XY order with X first, then Y, then eject
  function automatic int expected_port(input coord_t x, input coord_t y);
    if (x > LocalX) return int'(East);
    if (x < LocalX) return int'(West);
    if (y > LocalY) return int'(North);
    if (y < LocalY) return int'(South);
    return int'(Local);
  endfunction

  function automatic logic starts_packet(input flit_kind_e kind);
    return (kind == Head) || (kind == Single);
  endfunction

  // Body words carry tag and sequence on top, flit index below
  function automatic flit_t make_flit(input int port, input coord_t x, input coord_t y,
                                      input logic [15:0] seq, input int idx, input int len);
    flit_t f;
    if (len == 1) f.kind = Single;
    else if (idx == 0) f.kind = Head;
    else if (idx == len - 1) f.kind = Tail;
    else f.kind = Body;
    if (idx == 0) begin
      f.payload.hdr.dst_x   = x;
      f.payload.hdr.dst_y   = y;
      f.payload.hdr.src_tag = 8'(port);
      f.payload.hdr.seq_num = seq;
    end else begin
      f.payload.data = {8'(port), seq, 8'(idx)};
    end
    return f;
  endfunction

  // North and South inputs stay in their column
  task automatic new_packet(input int p);
    pkt_len[p]  = 1 + int'($unsigned($random(seed)) % 4);
    flit_idx[p] = 0;
    if (p == North || p == South) dst_x[p] = LocalX;
    else dst_x[p] = coord_t'($unsigned($random(seed)) % 5);
    dst_y[p] = coord_t'($unsigned($random(seed)) % 5);
  endtask

  task automatic wait_drain(input string phase);
    int n;
    n = 0;
    while (rcv_count != sent_count && n < DrainTimeout) begin
      @(negedge clk);
      n++;
    end
    if (rcv_count != sent_count) begin
      error_count++;
      $display("Timeout in %s: received %0d of %0d flits", phase, rcv_count, sent_count);
    end
  endtask

  // Reference state built from the output handshakes
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_seen_q <= 1'b0;
      rcv_count  <= 0;
      open_q     <= '0;
      for (int i = 0; i < 256; i++) exp_seq_q[i] <= '0;
    end else begin
      rst_seen_q <= 1'b1;
      rcv_count  <= rcv_count + $countones(out_valid & out_ready);
      for (int p = 0; p < NumPorts; p++) begin
        if (out_valid[p] && out_ready[p]) begin
          if (out_data[p].kind == Head) begin
            open_q[p] <= 1'b1;
            tag_q[p]  <= out_data[p].payload.hdr.src_tag;
            seq_q[p]  <= out_data[p].payload.hdr.seq_num;
          end else if (out_data[p].kind == Tail) begin
            open_q[p] <= 1'b0;
          end
          if (starts_packet(out_data[p].kind))
            exp_seq_q[out_data[p].payload.hdr.src_tag] <= out_data[p].payload.hdr.seq_num + 16'd1;
        end
      end
    end
  end

  always @(posedge clk) begin
    for (int p = 0; p < NumPorts; p++) prev_data_q[p] <= out_data[p];
  end

  a_reset: assert property (@(posedge clk) (!rst_n || !rst_seen_q) |->
    out_valid == '0 && in_ready == '1)
    else begin
      error_count++;
      $display("mismatch reset: expected valid 00 ready 1f, actual valid %h ready %h",
               $sampled(out_valid), $sampled(in_ready));
    end

  for (genvar p = 0; p < NumPorts; p++) begin : gen_check
    a_routing: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[p] && starts_packet(out_data[p].kind) |->
      expected_port(out_data[p].payload.hdr.dst_x, out_data[p].payload.hdr.dst_y) == p)
      else begin
        error_count++;
        $display("mismatch routing: expected port %0d, actual port %0d",
                 expected_port($sampled(out_data[p].payload.hdr.dst_x),
                               $sampled(out_data[p].payload.hdr.dst_y)), p);
      end

    a_wormhole: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[p] && !starts_packet(out_data[p].kind) |->
      open_q[p] && out_data[p].payload.data[31:8] == {tag_q[p], seq_q[p]})
      else begin
        error_count++;
        $display("mismatch wormhole port %0d: expected %h, actual %h", p,
                 {$sampled(tag_q[p]), $sampled(seq_q[p])},
                 $sampled(out_data[p].payload.data[31:8]));
      end

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[p] && out_ready[p] && starts_packet(out_data[p].kind) |->
      out_data[p].payload.hdr.src_tag < NumPorts &&
      out_data[p].payload.hdr.seq_num == exp_seq_q[out_data[p].payload.hdr.src_tag])
      else begin
        error_count++;
        $display("mismatch order source %0d: expected seq %0d, actual seq %0d",
                 $sampled(out_data[p].payload.hdr.src_tag),
                 $sampled(exp_seq_q[out_data[p].payload.hdr.src_tag]),
                 $sampled(out_data[p].payload.hdr.seq_num));
      end

    a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid[p] && !out_ready[p] |=> out_valid[p] && out_data[p] == prev_data_q[p])
      else begin
        error_count++;
        $display("mismatch backpressure port %0d: expected %h, actual %h", p,
                 $sampled(prev_data_q[p]), $sampled(out_data[p]));
      end
  end

  initial begin
    in_valid  = '0;
    in_data   = '0;
    out_ready = '1;
    active    = '0;
    for (int p = 0; p < NumPorts; p++) begin
      pkts_sent[p] = 0;
      seq_num[p]   = '0;
    end
    cycles = 0;
    while (rst_seen_q !== 1'b1 && cycles < 100) begin
      @(posedge clk);
      cycles++;
    end
    if (rst_seen_q !== 1'b1) begin
      error_count++;
      $display("Reset was never released");
    end

    // Random traffic on all inputs
    cycles = 0;
    while (cycles < StimTimeout && (active != '0 || pkts_sent.sum() < NumPkts * NumPorts)) begin
      @(posedge clk);
      accepted = in_valid & in_ready;
      @(negedge clk);
      cycles++;
      sent_count += $countones(accepted);
      for (int p = 0; p < NumPorts; p++) begin
        if (accepted[p]) begin
          flit_idx[p]++;
          if (flit_idx[p] == pkt_len[p]) begin
            pkts_sent[p]++;
            seq_num[p]++;
            active[p] = 1'b0;
          end
        end
        if (!active[p] && pkts_sent[p] < NumPkts) begin
          new_packet(p);
          active[p] = 1'b1;
        end
        in_valid[p] = active[p];
        if (active[p])
          in_data[p] = make_flit(p, dst_x[p], dst_y[p], seq_num[p], flit_idx[p], pkt_len[p]);
        out_ready[p] = ($unsigned($random(seed)) % 4) != 0;
      end
    end
    if (cycles >= StimTimeout) begin
      error_count++;
      $display("Random stimulus did not finish in time");
    end
    out_ready = '1;
    wait_drain("random traffic");

    // Burst into the local input with its output stalled
    @(negedge clk);
    out_ready[Local] = 1'b0;
    in_valid[Local]  = 1'b1;
    in_data[Local]   = make_flit(Local, LocalX, LocalY, seq_num[Local], 0, 1);
    burst_count = 0;
    full_seen   = 1'b0;
    cycles      = 0;
    while (!full_seen && cycles < BurstTimeout) begin
      @(posedge clk);
      full_seen = !in_ready[Local];
      @(negedge clk);
      cycles++;
      if (!full_seen) begin
        burst_count++;
        seq_num[Local]++;
        in_data[Local] = make_flit(Local, LocalX, LocalY, seq_num[Local], 0, 1);
      end
    end
    if (!full_seen) begin
      error_count++;
      $display("Input ready never dropped during the stalled burst");
    end
    a_burst_fill: assert (burst_count <= InFifoDepth + 1)
      else begin
        error_count++;
        $display("mismatch burst fill: expected at most %0d flits, actual %0d",
                 InFifoDepth + 1, burst_count);
      end

    // Let the held flit in, then drain
    out_ready[Local] = 1'b1;
    accepted = '0;
    cycles   = 0;
    while (!accepted[Local] && cycles < BurstTimeout) begin
      @(posedge clk);
      accepted = in_valid & in_ready;
      @(negedge clk);
      cycles++;
    end
    in_valid[Local] = 1'b0;
    if (accepted[Local]) begin
      burst_count++;
      seq_num[Local]++;
    end else begin
      error_count++;
      $display("Held burst flit was never accepted");
    end
    sent_count += burst_count;
    wait_drain("burst");

    $display("Errors: %0d, flits sent: %0d, flits received: %0d",
             error_count, sent_count, rcv_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- noc_router.f
noc_pkg.sv
noc_in_fifo.sv
noc_xy_route.sv
noc_wormhole_arb.sv
noc_router.sv
tb_clk_gen.sv
tb_noc_router.sv
